// File: logic/rtc_params.svh
/*
 Constants for the RTC register block: word indices, port widths,
 control reset value and control bit positions. Include where needed
*/
`ifndef RTC_PARAMS_SVH
`define RTC_PARAMS_SVH

// Port widths ------------------------
`define RTC_ADDR_W          5       // Byte address, word index in 4:2
`define RTC_DATA_W          32
`define RTC_BE_W            4

// Word indices -----------------------
`define RTC_REG_CMD         3'd0    // Update / capture strobes
`define RTC_REG_TIME        3'd1
`define RTC_REG_DATE        3'd2
`define RTC_REG_ALRM1       3'd3
`define RTC_REG_ALRM2       3'd4
`define RTC_REG_CTRL        3'd5

// Control field ----------------------
`define RTC_CTRL_RST        16'h0400  // 24 hour mode out of reset

`define RTC_CTRL_ALRM1_IE   8
`define RTC_CTRL_ALRM2_IE   9
`define RTC_CTRL_HMODE      10      // 1 = 24 hour
`define RTC_CTRL_HALT       11
`define RTC_CTRL_RESET      12
`define RTC_CTRL_FAST_TIME  14
`define RTC_CTRL_FAST_DATE  15

// Sticky status in the control read word
`define RTC_STAT_LSB        16

`endif

// File: logic/rtc_pkg.sv
/*
 Shared types for the RTC register block. Register words, BCD time and
 date layouts, alarm modes and the control field
*/
`include "rtc_params.svh"

package rtc_pkg;

  typedef logic [`RTC_DATA_W-1:0] reg_word_t;
  typedef logic [`RTC_BE_W-1:0]   byte_en_t;
  typedef logic [2:0]             reg_idx_t;   // Address bits 4:2
  typedef logic [15:0]            ctrl_word_t; // Lower half of control word

  // BCD time, also the alarm word layout
  typedef struct packed {
    logic [4:0] pad_dow;
    logic [2:0] dow;        // Day of week
    logic [1:0] pad_hour;
    logic [1:0] ten_hour;
    logic [3:0] hour;
    logic       pad_min;
    logic [2:0] ten_min;
    logic [3:0] min;
    logic       pad_sec;
    logic [2:0] ten_sec;
    logic [3:0] sec;
  } time_word_t;

  // BCD date
  typedef struct packed {
    logic [3:0] ten_cent;
    logic [3:0] cent;
    logic [3:0] ten_year;
    logic [3:0] year;
    logic [2:0] pad_mon;
    logic       ten_mon;
    logic [3:0] mon;
    logic [1:0] pad_day;
    logic [1:0] ten_day;
    logic [3:0] day;
  } date_word_t;

  // Codes 8 to 15 behave as off
  typedef enum logic [3:0] {
    ALARM_OFF        = 4'd0,
    ALARM_SEC_PULSE  = 4'd1,
    ALARM_MIN_PULSE  = 4'd2,
    ALARM_HOUR_PULSE = 4'd3,
    ALARM_MATCH_S    = 4'd4,  // Seconds
    ALARM_MATCH_SM   = 4'd5,  // + minutes
    ALARM_MATCH_SMH  = 4'd6,  // + hours
    ALARM_MATCH_SMHD = 4'd7   // + day of week
  } alarm_mode_t;

endpackage

// File: logic/rtc_reg_access.sv
/*
 Register port front end. Decodes the word index, raises the acknowledge
 one cycle after select and gives one write strobe per register.
 Read-back word is registered alongside the acknowledge
*/
`timescale 1ns/10ps
`include "rtc_params.svh"

module rtc_reg_access import rtc_pkg::*; (
  input  logic                  rtc_clk,
  input  logic                  rst_n,
  // Host port
  input  logic                  reg_cs,
  input  logic [`RTC_ADDR_W-1:0] reg_addr,
  input  logic                  reg_wr,
  input  byte_en_t              reg_be,
  // Stored words for read-back
  input  time_word_t            cfg_time,
  input  date_word_t            cfg_date,
  input  reg_word_t             alarm1_word,
  input  reg_word_t             alarm2_word,
  input  ctrl_word_t            ctrl,
  input  logic [1:0]            intr_stat,
  // Write strobes
  output logic                  cmd_we,
  output logic                  time_we,
  output logic                  date_we,
  output logic                  alrm1_we,
  output logic                  alrm2_we,
  output logic                  ctrl_we,
  // Response
  output reg_word_t             reg_rdata,
  output logic                  reg_ack
);

  reg_idx_t  reg_idx;
  logic      acc_go;   // Access accepted this cycle
  logic      wr_go;
  reg_word_t ctrl_rd;  // Status over control field
  reg_word_t rd_word;

  assign reg_idx = reg_idx_t'(reg_addr[4:2]);
  assign acc_go  = reg_cs & ~reg_ack;           // Blocked during ack
  assign wr_go   = acc_go & reg_wr & (|reg_be); // Writes with no lanes are dropped

  // Write strobes ------------------
  // One cycle, the register updates on the edge that raises reg_ack
  assign cmd_we   = wr_go & (reg_idx == `RTC_REG_CMD);
  assign time_we  = wr_go & (reg_idx == `RTC_REG_TIME);
  assign date_we  = wr_go & (reg_idx == `RTC_REG_DATE);
  assign alrm1_we = wr_go & (reg_idx == `RTC_REG_ALRM1);
  assign alrm2_we = wr_go & (reg_idx == `RTC_REG_ALRM2);
  assign ctrl_we  = wr_go & (reg_idx == `RTC_REG_CTRL);

  // Read-back mux ------------------
  always_comb begin
    ctrl_rd = '0;
    ctrl_rd[15:0] = ctrl;
    ctrl_rd[`RTC_STAT_LSB +: 2] = intr_stat; // Sticky alarm status
  end

  always_comb begin
    case (reg_idx)
      `RTC_REG_TIME:  rd_word = reg_word_t'(cfg_time);
      `RTC_REG_DATE:  rd_word = reg_word_t'(cfg_date);
      `RTC_REG_ALRM1: rd_word = alarm1_word;
      `RTC_REG_ALRM2: rd_word = alarm2_word;
      `RTC_REG_CTRL:  rd_word = ctrl_rd;
      default:        rd_word = '0;   // Command and unused words
    endcase
  end

  // Acknowledge --------------------
  // High one cycle, then low at least one cycle while cs is held
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= acc_go;
    end
  end

  // Captured with the ack edge, valid while ack is high
  always_ff @(posedge rtc_clk) begin
    if (acc_go) begin
      reg_rdata <= rd_word;
    end
  end

endmodule

// File: logic/rtc_cfg_regs.sv
/*
 Configuration registers of the RTC. Byte-enabled time, date, alarm and
 control words, the update / capture command pulses and the capture of
 the running counters into the time and date words
*/
`timescale 1ns/10ps
`include "rtc_params.svh"

module rtc_cfg_regs import rtc_pkg::*; (
  input  logic        rtc_clk,
  input  logic        rst_n,
  input  reg_word_t   reg_wdata,
  input  byte_en_t    reg_be,
  // Strobes from the access block
  input  logic        cmd_we,
  input  logic        time_we,
  input  logic        date_we,
  input  logic        alrm1_we,
  input  logic        alrm2_we,
  input  logic        ctrl_we,
  // Packed running counters
  input  time_word_t  rtc_time,
  input  date_word_t  rtc_date,
  // Stored words
  output time_word_t  cfg_time,
  output date_word_t  cfg_date,
  output reg_word_t   alarm1_word,
  output reg_word_t   alarm2_word,
  output alarm_mode_t alarm1_mode,
  output alarm_mode_t alarm2_mode,
  output ctrl_word_t  ctrl,
  // RTC core controls
  output logic        cfg_rtc_update,
  output logic        cfg_rtc_capture,
  output logic        cfg_hmode,
  output logic        cfg_rtc_halt,
  output logic        cfg_rtc_reset,
  output logic        cfg_fast_time,
  output logic        cfg_fast_date
);

  reg_word_t ctrl_merged;

  // Replace the enabled byte lanes of old_word
  function automatic reg_word_t be_merge(reg_word_t old_word, reg_word_t new_word,
                                         byte_en_t be);
    reg_word_t merged;
    merged = old_word;
    for (int i = 0; i < `RTC_BE_W; i++) begin
      if (be[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // Command pulses -----------------
  // Rise with reg_ack, gone the next cycle
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_rtc_update  <= 1'b0;
      cfg_rtc_capture <= 1'b0;
    end else begin
      cfg_rtc_update  <= cmd_we & reg_be[0] & reg_wdata[0];
      cfg_rtc_capture <= cmd_we & reg_be[0] & reg_wdata[1];
    end
  end

  // Time and date ------------------
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_time <= '0;
      cfg_date <= '0;
    end else begin
      if (time_we) begin
        cfg_time <= be_merge(cfg_time, reg_wdata, reg_be); // Write beats capture
      end else if (cfg_rtc_capture) begin
        cfg_time <= rtc_time;
      end
      if (date_we) begin
        cfg_date <= be_merge(cfg_date, reg_wdata, reg_be);
      end else if (cfg_rtc_capture) begin
        cfg_date <= rtc_date;
      end
    end
  end

  // Alarm words --------------------
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      alarm1_word <= '0;
      alarm2_word <= '0;
    end else begin
      if (alrm1_we) begin
        alarm1_word <= be_merge(alarm1_word, reg_wdata, reg_be);
      end
      if (alrm2_we) begin
        alarm2_word <= be_merge(alarm2_word, reg_wdata, reg_be);
      end
    end
  end

  // Control ------------------------
  // Bytes 2 and 3 hold status, kept in the interrupt block
  assign ctrl_merged = be_merge(reg_word_t'(ctrl), reg_wdata, reg_be & byte_en_t'(4'b0011));

  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl <= `RTC_CTRL_RST;
    end else if (ctrl_we) begin
      ctrl <= ctrl_merged[15:0];
    end
  end

  assign alarm1_mode   = alarm_mode_t'(ctrl[3:0]);
  assign alarm2_mode   = alarm_mode_t'(ctrl[7:4]);
  assign cfg_hmode     = ctrl[`RTC_CTRL_HMODE];     // 0 = 12 hour
  assign cfg_rtc_halt  = ctrl[`RTC_CTRL_HALT];
  assign cfg_rtc_reset = ctrl[`RTC_CTRL_RESET];
  assign cfg_fast_time = ctrl[`RTC_CTRL_FAST_TIME];
  assign cfg_fast_date = ctrl[`RTC_CTRL_FAST_DATE];

endmodule

// File: logic/rtc_alarm_match.sv
/*
 One alarm comparator. Periodic modes pass an increment pulse through,
 match modes compare the alarm word against the BCD time counters.
 Purely combinational, one instance per alarm
*/
`timescale 1ns/10ps

module rtc_alarm_match import rtc_pkg::*; (
  input  alarm_mode_t alarm_mode,
  input  reg_word_t   alarm_word,
  input  time_word_t  rtc_time,
  input  logic        inc_time_s,   // Second tick
  input  logic        inc_time_m,   // Minute tick
  input  logic        inc_time_h,   // Hour tick
  output logic        alarm_hit
);

  time_word_t alm;      // Alarm word in time layout
  logic       s_eq;
  logic       sm_eq;
  logic       smh_eq;
  logic       smhd_eq;

  assign alm = time_word_t'(alarm_word);

  // Cumulative field equality ------
  assign s_eq    = (alm.sec == rtc_time.sec) &&
                   (alm.ten_sec == rtc_time.ten_sec);
  assign sm_eq   = s_eq &&
                   (alm.min == rtc_time.min) &&
                   (alm.ten_min == rtc_time.ten_min);
  assign smh_eq  = sm_eq &&
                   (alm.hour == rtc_time.hour) &&
                   (alm.ten_hour == rtc_time.ten_hour);
  assign smhd_eq = smh_eq && (alm.dow == rtc_time.dow);

  // Mode select
  // Match modes give a level for as long as the fields agree
  always_comb begin
    case (alarm_mode)
      ALARM_SEC_PULSE:  alarm_hit = inc_time_s;
      ALARM_MIN_PULSE:  alarm_hit = inc_time_m;
      ALARM_HOUR_PULSE: alarm_hit = inc_time_h;
      ALARM_MATCH_S:    alarm_hit = s_eq;
      ALARM_MATCH_SM:   alarm_hit = sm_eq;
      ALARM_MATCH_SMH:  alarm_hit = smh_eq;
      ALARM_MATCH_SMHD: alarm_hit = smhd_eq;
      default:          alarm_hit = 1'b0;  // Off, codes 8 to 15 too
    endcase
  end

endmodule

// File: logic/rtc_intr_ctrl.sv
/*
 Alarm interrupt status and request. Status bits are sticky, cleared by
 writing 1 to them in byte 2 of the control word. Request is the
 enabled hits, not the status
*/
`timescale 1ns/10ps
`include "rtc_params.svh"

module rtc_intr_ctrl import rtc_pkg::*; (
  input  logic       rtc_clk,
  input  logic       rst_n,
  input  logic       ctrl_we,
  input  byte_en_t   reg_be,
  input  reg_word_t  reg_wdata,
  input  logic       alarm1_hit,
  input  logic       alarm2_hit,
  input  logic       alarm1_ie,
  input  logic       alarm2_ie,
  output logic [1:0] intr_stat,
  output logic       rtc_intr
);

  logic [1:0] hit;
  logic [1:0] stat_clr;   // Write-1-clear per bit

  assign hit = {alarm2_hit, alarm1_hit};

  assign stat_clr[0] = ctrl_we & reg_be[`RTC_STAT_LSB/8] & reg_wdata[`RTC_STAT_LSB];
  assign stat_clr[1] = ctrl_we & reg_be[`RTC_STAT_LSB/8] & reg_wdata[`RTC_STAT_LSB+1];

  // Sticky status ------------------
  always_ff @(posedge rtc_clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_stat <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (stat_clr[i]) begin
          intr_stat[i] <= hit[i];   // Hit in the clear cycle survives
        end else begin
          intr_stat[i] <= intr_stat[i] | hit[i];
        end
      end
    end
  end

  // Same cycle as the hit
  assign rtc_intr = (alarm1_hit & alarm1_ie) | (alarm2_hit & alarm2_ie);

endmodule

// File: logic/rtc_reg.sv
/*
 Register block of the 32768 Hz real-time clock. Packs the BCD counters
 from the RTC core, serves the register port and raises the alarm
 interrupt. Instantiate next to the counter core on the same clock
*/
`timescale 1ns/10ps
`include "rtc_params.svh"

module rtc_reg import rtc_pkg::*; (
  input  logic                   rtc_clk,
  input  logic                   rst_n,
  // Register port
  input  logic                   reg_cs,
  input  logic [`RTC_ADDR_W-1:0] reg_addr,
  input  reg_word_t              reg_wdata,
  input  byte_en_t               reg_be,
  input  logic                   reg_wr,
  output reg_word_t              reg_rdata,
  output logic                   reg_ack,
  output logic                   rtc_intr,
  // Increment pulses
  input  logic                   inc_time_s,
  input  logic                   inc_time_m,
  input  logic                   inc_time_h,
  // Time counters
  input  logic [3:0]             time_s,
  input  logic [2:0]             time_ts,
  input  logic [3:0]             time_m,
  input  logic [2:0]             time_tm,
  input  logic [3:0]             time_h,
  input  logic [1:0]             time_th,
  input  logic [2:0]             time_dow,
  // Date counters
  input  logic [3:0]             date_d,
  input  logic [1:0]             date_td,
  input  logic [3:0]             date_m,
  input  logic                   date_tm,
  input  logic [3:0]             date_y,
  input  logic [3:0]             date_ty,
  input  logic [3:0]             date_c,
  input  logic [3:0]             date_tc,
  // RTC core controls
  output logic                   cfg_rtc_update,
  output logic                   cfg_rtc_capture,
  output logic                   cfg_rtc_halt,
  output logic                   cfg_rtc_reset,
  output logic                   cfg_fast_time,
  output logic                   cfg_fast_date,
  output logic                   cfg_hmode,
  output time_word_t             cfg_time,
  output date_word_t             cfg_date
);

  time_word_t  rtc_time;
  date_word_t  rtc_date;
  logic        cmd_we, time_we, date_we, alrm1_we, alrm2_we, ctrl_we;
  reg_word_t   alarm1_word, alarm2_word;
  alarm_mode_t alarm1_mode, alarm2_mode;
  ctrl_word_t  ctrl;
  logic [1:0]  intr_stat;
  logic        alarm1_hit, alarm2_hit;

  // Counter packing ----------------
  always_comb begin
    rtc_time          = '0;          // Pads read 0
    rtc_time.sec      = time_s;
    rtc_time.ten_sec  = time_ts;
    rtc_time.min      = time_m;
    rtc_time.ten_min  = time_tm;
    rtc_time.hour     = time_h;
    rtc_time.ten_hour = time_th;
    rtc_time.dow      = time_dow;
    rtc_date          = '0;
    rtc_date.day      = date_d;
    rtc_date.ten_day  = date_td;
    rtc_date.mon      = date_m;
    rtc_date.ten_mon  = date_tm;
    rtc_date.year     = date_y;
    rtc_date.ten_year = date_ty;
    rtc_date.cent     = date_c;
    rtc_date.ten_cent = date_tc;
  end

  rtc_reg_access u_access (.rtc_clk, .rst_n, .reg_cs, .reg_addr, .reg_wr, .reg_be,
    .cfg_time, .cfg_date, .alarm1_word, .alarm2_word, .ctrl, .intr_stat,
    .cmd_we, .time_we, .date_we, .alrm1_we, .alrm2_we, .ctrl_we, .reg_rdata, .reg_ack);

  rtc_cfg_regs u_cfg (.rtc_clk, .rst_n, .reg_wdata, .reg_be,
    .cmd_we, .time_we, .date_we, .alrm1_we, .alrm2_we, .ctrl_we, .rtc_time, .rtc_date,
    .cfg_time, .cfg_date, .alarm1_word, .alarm2_word, .alarm1_mode, .alarm2_mode, .ctrl,
    .cfg_rtc_update, .cfg_rtc_capture, .cfg_hmode, .cfg_rtc_halt, .cfg_rtc_reset,
    .cfg_fast_time, .cfg_fast_date);

  // Two identical comparators ------
  rtc_alarm_match u_alarm1 (.alarm_mode(alarm1_mode), .alarm_word(alarm1_word), .rtc_time,
    .inc_time_s, .inc_time_m, .inc_time_h, .alarm_hit(alarm1_hit));

  rtc_alarm_match u_alarm2 (.alarm_mode(alarm2_mode), .alarm_word(alarm2_word), .rtc_time,
    .inc_time_s, .inc_time_m, .inc_time_h, .alarm_hit(alarm2_hit));

  rtc_intr_ctrl u_intr (.rtc_clk, .rst_n, .ctrl_we, .reg_be, .reg_wdata,
    .alarm1_hit, .alarm2_hit,
    .alarm1_ie(ctrl[`RTC_CTRL_ALRM1_IE]), .alarm2_ie(ctrl[`RTC_CTRL_ALRM2_IE]),
    .intr_stat, .rtc_intr);

endmodule

// File: tb/rtc_reg_chk.sv
/*
 Protocol checks on the RTC register block, bound into rtc_reg by the
 testbench. Acknowledge shape, command pulses and interrupt gating
*/
`timescale 1ns/10ps

module rtc_reg_chk (
  input logic rtc_clk,
  input logic rst_n,
  input logic reg_ack,
  input logic cfg_rtc_update,
  input logic cfg_rtc_capture,
  input logic rtc_intr,
  input logic alarm1_ie,
  input logic alarm2_ie
);

  // Access shape -------------------
  ack_one_cycle: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    reg_ack |=> !reg_ack)
    else $error("reg_ack high for two cycles in a row");

  // Command pulses ride on the ack
  cmd_with_ack: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    (cfg_rtc_update | cfg_rtc_capture) |-> reg_ack)
    else $error("Command pulse without reg_ack");

  // Interrupt gating ---------------
  intr_gated: assert property (@(posedge rtc_clk) disable iff (!rst_n)
    (!alarm1_ie && !alarm2_ie) |-> !rtc_intr)
    else $error("rtc_intr high with both enables low");

endmodule

// File: tb/rtc_reg_tb.sv
/*
 Testbench of the RTC register block. Runs the accesses, counter
 settings and pulses of tb/rtc_reg_cases.txt against a byte merge model
 and stops at the first mismatch. Run from the project root
*/
`timescale 1ns/10ps
`include "rtc_params.svh"

module rtc_reg_tb import rtc_pkg::*; ();

  typedef struct {
    string     op;
    logic [4:0] addr;
    byte_en_t  be;
    reg_word_t wdata;
    reg_word_t ctime;
    reg_word_t cdate;
    logic [2:0] pulse;    // {h, m, s}
    reg_word_t exp_rdata;
    logic      exp_intr;
  } case_t;

  logic rtc_clk, rst_n, reg_cs, reg_wr, reg_ack, rtc_intr;
  logic [`RTC_ADDR_W-1:0] reg_addr;
  reg_word_t reg_wdata, reg_rdata;
  byte_en_t  reg_be;
  logic inc_time_s, inc_time_m, inc_time_h;
  logic cfg_rtc_update, cfg_rtc_capture, cfg_rtc_halt, cfg_rtc_reset;
  logic cfg_fast_time, cfg_fast_date, cfg_hmode;
  time_word_t cfg_time, drv_time;
  date_word_t cfg_date, drv_date;

  case_t     cases[$];
  reg_word_t model_reg[0:7];   // Expected stored words by index
  logic [31:0] lcg_state = 32'h2d3f;
  int        cycles = 0;
  int        cycle_limit = 1000;

  rtc_reg i_rtc_reg (.rtc_clk, .rst_n, .reg_cs, .reg_addr, .reg_wdata, .reg_be, .reg_wr,
    .reg_rdata, .reg_ack, .rtc_intr, .inc_time_s, .inc_time_m, .inc_time_h,
    .time_s(drv_time.sec), .time_ts(drv_time.ten_sec), .time_m(drv_time.min),
    .time_tm(drv_time.ten_min), .time_h(drv_time.hour), .time_th(drv_time.ten_hour),
    .time_dow(drv_time.dow), .date_d(drv_date.day), .date_td(drv_date.ten_day),
    .date_m(drv_date.mon), .date_tm(drv_date.ten_mon), .date_y(drv_date.year),
    .date_ty(drv_date.ten_year), .date_c(drv_date.cent), .date_tc(drv_date.ten_cent),
    .cfg_rtc_update, .cfg_rtc_capture, .cfg_rtc_halt, .cfg_rtc_reset, .cfg_fast_time,
    .cfg_fast_date, .cfg_hmode, .cfg_time, .cfg_date);

  initial begin
    rtc_clk = 1'b0;
    forever #10 rtc_clk = ~rtc_clk;  // 20 ns
  end

  // Hung run guard
  always @(posedge rtc_clk) begin
    cycles++;
    if (cycles > cycle_limit) report_fail("Timeout, the run took too many cycles");
  end

  // Checking -----------------------
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic compare_word(input string name, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_time(input string name, input time_word_t got, input time_word_t exp);
    if (got !== exp) report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_date(input string name, input date_word_t got, input date_word_t exp);
    if (got !== exp) report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_fail($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lane merge as the register map defines it
  function automatic reg_word_t merge_lanes(reg_word_t old_w, reg_word_t new_w, byte_en_t be);
    reg_word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // Host access --------------------
  // Returns on the falling edge where reg_ack is high, select still held
  task automatic run_access(input logic wr, input logic [4:0] addr, input byte_en_t be,
                            input reg_word_t wd);
    int waited;
    @(negedge rtc_clk);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_be    = be;
    reg_wdata = wd;
    waited    = 0;
    do begin
      @(negedge rtc_clk);
      waited++;
      if (!reg_ack && waited >= 4) report_fail("No reg_ack within 4 cycles of select");
    end while (!reg_ack);
  endtask

  task automatic write_and_check(input logic [4:0] addr, input byte_en_t be,
                                 input reg_word_t wd);
    reg_idx_t idx;
    logic     is_cmd;
    idx    = addr[4:2];
    is_cmd = (idx == `RTC_REG_CMD) && (|be);
    run_access(1'b1, addr, be, wd);
    compare_bit("cfg_rtc_update", cfg_rtc_update, is_cmd & be[0] & wd[0]);
    compare_bit("cfg_rtc_capture", cfg_rtc_capture, is_cmd & be[0] & wd[1]);
    reg_cs = 1'b0;
    if (idx == `RTC_REG_CTRL) begin
      model_reg[idx] = merge_lanes(model_reg[idx], wd, byte_en_t'(be & 4'b0011));
      compare_bit("cfg_hmode", cfg_hmode, model_reg[idx][`RTC_CTRL_HMODE]);
      compare_bit("cfg_rtc_halt", cfg_rtc_halt, model_reg[idx][`RTC_CTRL_HALT]);
      compare_bit("cfg_rtc_reset", cfg_rtc_reset, model_reg[idx][`RTC_CTRL_RESET]);
      compare_bit("cfg_fast_time", cfg_fast_time, model_reg[idx][`RTC_CTRL_FAST_TIME]);
      compare_bit("cfg_fast_date", cfg_fast_date, model_reg[idx][`RTC_CTRL_FAST_DATE]);
    end else if (idx != `RTC_REG_CMD && idx < 3'd5) begin
      model_reg[idx] = merge_lanes(model_reg[idx], wd, be);
    end
    if (is_cmd && be[0] && wd[1]) begin
      @(negedge rtc_clk);  // Capture lands one cycle after the pulse
      compare_time("cfg_time", cfg_time, drv_time);
      compare_date("cfg_date", cfg_date, drv_date);
      model_reg[`RTC_REG_TIME] = drv_time;
      model_reg[`RTC_REG_DATE] = drv_date;
    end
  endtask

  task automatic read_and_check(input logic [4:0] addr, input reg_word_t exp);
    run_access(1'b0, addr, 4'h0, '0);
    compare_word("reg_rdata", reg_rdata, exp);
    reg_cs = 1'b0;
  endtask

  // Case file ----------------------
  task automatic load_cases();
    int    fd;
    int    n;
    string line;
    case_t c;
    fd = $fopen("tb/rtc_reg_cases.txt", "r");
    if (fd == 0) report_fail("Cannot open tb/rtc_reg_cases.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", c.op, c.addr, c.be, c.wdata,
                  c.ctime, c.cdate, c.pulse, c.exp_rdata, c.exp_intr);
      if (n != 9) report_fail($sformatf("Malformed case line: %s", line));
      cases.push_back(c);
    end
    $fclose(fd);
  endtask

  initial begin
    int units;
    reg_word_t rnd;
    rst_n = 1'b0;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_be = '0;
    reg_wdata = '0;
    inc_time_s = 1'b0;
    inc_time_m = 1'b0;
    inc_time_h = 1'b0;
    drv_time = '0;
    drv_date = '0;
    for (int i = 0; i < 8; i++) model_reg[i] = '0;
    model_reg[`RTC_REG_CTRL] = `RTC_CTRL_RST;
    load_cases();
    units = cases.size();
    foreach (cases[i]) if (cases[i].op == "rand") units += cases[i].wdata;
    cycle_limit = 40 * units + 20;

    repeat (8) @(negedge rtc_clk);
    rst_n = 1'b1;
    compare_bit("reg_ack", reg_ack, 1'b0);
    compare_bit("cfg_rtc_update", cfg_rtc_update, 1'b0);
    compare_bit("cfg_rtc_capture", cfg_rtc_capture, 1'b0);
    compare_bit("rtc_intr", rtc_intr, 1'b0);
    compare_bit("cfg_hmode", cfg_hmode, 1'b1);

    foreach (cases[i]) begin
      case (cases[i].op)
        "read":  read_and_check(cases[i].addr, cases[i].exp_rdata);
        "write": write_and_check(cases[i].addr, cases[i].be, cases[i].wdata);
        "counters": begin
          @(negedge rtc_clk);
          drv_time = cases[i].ctime;
          drv_date = cases[i].cdate;
          #5 compare_bit("rtc_intr", rtc_intr, cases[i].exp_intr);
        end
        "pulse": begin
          @(negedge rtc_clk);
          {inc_time_h, inc_time_m, inc_time_s} = cases[i].pulse;
          #5 compare_bit("rtc_intr", rtc_intr, cases[i].exp_intr);
          @(negedge rtc_clk);
          {inc_time_h, inc_time_m, inc_time_s} = 3'b000;
        end
        "rand": begin
          for (int k = 0; k < cases[i].wdata; k++) begin
            rnd = lcg_next();
            write_and_check(cases[i].addr, byte_en_t'(lcg_next() >> 16), rnd);
            read_and_check(cases[i].addr, model_reg[cases[i].addr[4:2]]);
          end
        end
        default: report_fail($sformatf("Unknown case operation %s", cases[i].op));
      endcase
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

bind rtc_reg rtc_reg_chk u_chk (.rtc_clk, .rst_n, .reg_ack, .cfg_rtc_update,
  .cfg_rtc_capture, .rtc_intr, .alarm1_ie(ctrl[`RTC_CTRL_ALRM1_IE]),
  .alarm2_ie(ctrl[`RTC_CTRL_ALRM2_IE]));

// File: project.f
+incdir+logic
logic/rtc_pkg.sv
logic/rtc_reg_access.sv
logic/rtc_cfg_regs.sv
logic/rtc_alarm_match.sv
logic/rtc_intr_ctrl.sv
logic/rtc_reg.sv
tb/rtc_reg_chk.sv
tb/rtc_reg_tb.sv

// File: tb/rtc_reg_cases.txt
# op addr be wdata ctime cdate pulse(h,m,s) exp_rdata exp_intr   (all hex)
# rand: wdata is the number of random write/read pairs on addr
read 14 0 0 0 0 0 00000400 0
read 04 0 0 0 0 0 00000000 0
read 08 0 0 0 0 0 00000000 0
read 0c 0 0 0 0 0 00000000 0
read 10 0 0 0 0 0 00000000 0
read 00 0 0 0 0 0 00000000 0
write 04 3 12345678 0 0 0 0 0
read 04 0 0 0 0 0 00005678 0
write 04 c aabbccdd 0 0 0 0 0
read 04 0 0 0 0 0 aabb5678 0
write 08 5 11223344 0 0 0 0 0
read 08 0 0 0 0 0 00220044 0
write 0c f 01234567 0 0 0 0 0
read 0c 0 0 0 0 0 01234567 0
write 10 2 0000ab00 0 0 0 0 0
read 10 0 0 0 0 0 0000ab00 0
write 14 f ffff5c00 0 0 0 0 0
read 14 0 0 0 0 0 00005c00 0
write 14 3 00000400 0 0 0 0 0
read 14 0 0 0 0 0 00000400 0
rand 04 0 6 0 0 0 0 0
rand 0c 0 6 0 0 0 0 0
rand 10 0 6 0 0 0 0 0
write 00 1 00000001 0 0 0 0 0
counters 0 0 0 03152148 20240715 0 0 0
write 00 1 00000002 0 0 0 0 0
read 04 0 0 0 0 0 03152148 0
read 08 0 0 0 0 0 20240715 0
write 0c f 03152148 0 0 0 0 0
write 14 3 00000104 0 0 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
counters 0 0 0 03152149 20240715 0 0 0
read 14 0 0 0 0 0 00010104 0
write 14 4 00010000 0 0 0 0 0
read 14 0 0 0 0 0 00000104 0
counters 0 0 0 03152148 20240715 0 0 1
write 14 4 00010000 0 0 0 0 0
read 14 0 0 0 0 0 00010104 0
write 14 3 00000105 0 0 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
counters 0 0 0 03153148 20240715 0 0 0
write 14 3 00000106 0 0 0 0 0
counters 0 0 0 03162148 20240715 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
write 14 3 00000107 0 0 0 0 0
counters 0 0 0 04152148 20240715 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
write 14 3 00000101 0 0 0 0 0
pulse 0 0 0 0 0 1 0 1
pulse 0 0 0 0 0 2 0 0
write 14 3 00000102 0 0 0 0 0
pulse 0 0 0 0 0 2 0 1
pulse 0 0 0 0 0 1 0 0
write 14 3 00000103 0 0 0 0 0
pulse 0 0 0 0 0 4 0 1
pulse 0 0 0 0 0 2 0 0
write 14 3 00000001 0 0 0 0 0
pulse 0 0 0 0 0 1 0 0
write 14 3 00000100 0 0 0 0 0
pulse 0 0 0 0 0 7 0 0
write 10 f 03152148 0 0 0 0 0
write 14 3 00000240 0 0 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
counters 0 0 0 03152149 20240715 0 0 0
read 14 0 0 0 0 0 00030240 0
write 14 4 00030000 0 0 0 0 0
read 14 0 0 0 0 0 00000240 0
write 14 3 00000230 0 0 0 0 0
pulse 0 0 0 0 0 4 0 1
pulse 0 0 0 0 0 1 0 0
write 14 3 00000270 0 0 0 0 0
counters 0 0 0 03152148 20240715 0 0 1
counters 0 0 0 05152148 20240715 0 0 0
